// File: verilog/nts_api_pkg.sv
/* Register bus widths, bank codes, address map and identity words
   for the engine identity bank and the debug bank */
`default_nettype none

package nts_api_pkg;

  // --------------------
  // Bus geometry
  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;
  localparam int BANK_W     = 4;   // Upper address bits
  localparam int OFFSET_W   = 8;   // Lower address bits

  // --------------------
  // Bank codes
  localparam logic [BANK_W-1:0] BANK_ENGINE = 4'd0;
  localparam logic [BANK_W-1:0] BANK_DEBUG  = 4'd1;

  // --------------------
  // Engine identity bank
  localparam logic [OFFSET_W-1:0] ADDR_NAME0   = 8'h00;
  localparam logic [OFFSET_W-1:0] ADDR_NAME1   = 8'h01;
  localparam logic [OFFSET_W-1:0] ADDR_VERSION = 8'h02;
  localparam logic [OFFSET_W-1:0] ADDR_CTRL    = 8'h08;

  localparam logic [API_DATA_W-1:0] CORE_NAME0   = 32'h4e54_535f; // "NTS_"
  localparam logic [API_DATA_W-1:0] CORE_NAME1   = 32'h454e_474e; // "ENGN"
  localparam logic [API_DATA_W-1:0] CORE_VERSION = 32'h302e_3033; // "0.03"
  localparam logic [API_DATA_W-1:0] CTRL_VALUE   = 32'h0000_0001;

  // --------------------
  // Debug bank
  localparam logic [API_DATA_W-1:0] DEBUG_NAME = 32'h4442_5547; // "DBUG"

  localparam logic [OFFSET_W-1:0] ADDR_DEBUG_NAME    = 8'h08;
  localparam logic [OFFSET_W-1:0] ADDR_DEBUG_SYSTICK = 8'h09;

  localparam logic [API_DATA_W-1:0] SYSTICK_RESET = 32'h0000_0001;

endpackage

`default_nettype wire

// File: verilog/nts_stats_pkg.sv
/* Event counter indices, counter address table and the 64-bit
   counter value seen as one word or as two halves */
`default_nettype none

package nts_stats_pkg;

  localparam int NUM_COUNTERS = 6;
  localparam int COUNT_W      = 64;

  // --------------------
  // Counter indices in event vector bit order
  localparam int CNT_PROCESSED    = 0;
  localparam int CNT_BAD_COOKIE   = 1;
  localparam int CNT_BAD_AUTH     = 2;
  localparam int CNT_BAD_KEYID    = 3;
  localparam int CNT_ERROR_CRYPTO = 4;
  localparam int CNT_ERROR_TXBUF  = 5;

  // Upper-word offset per counter with the lower word one above
  localparam logic [NUM_COUNTERS-1:0][nts_api_pkg::OFFSET_W-1:0] COUNTER_BASE = {
    8'h22,  // CNT_ERROR_TXBUF
    8'h20,  // CNT_ERROR_CRYPTO
    8'h06,  // CNT_BAD_KEYID
    8'h04,  // CNT_BAD_AUTH
    8'h02,  // CNT_BAD_COOKIE
    8'h00   // CNT_PROCESSED
  };

  // Counted as one word, read back as two bus words
  typedef union packed {
    logic [COUNT_W-1:0] word;
    struct packed {
      logic [COUNT_W/2-1:0] upper;
      logic [COUNT_W/2-1:0] lower;
    } half;
  } nts_count_u;

endpackage

`default_nettype wire

// File: verilog/nts_api_if.sv
/* Internal register bus from the bus decoder to the debug bank */
`timescale 1ns/1ps
`default_nettype none

interface nts_api_if;

  logic                                cs;         // Debug bank selected
  logic                                we;
  logic [nts_api_pkg::OFFSET_W-1:0]    address;    // Offset within the bank
  logic [nts_api_pkg::API_DATA_W-1:0]  read_data;  // Combinational

  modport decoder (
    output cs,
    output we,
    output address,
    input  read_data
  );

  modport bank (
    input  cs,
    input  we,
    input  address,
    output read_data
  );

endinterface

`default_nettype wire

// File: verilog/nts_counter_if.sv
/* Link between one event counter and the debug bank readout */
`timescale 1ns/1ps
`default_nettype none

interface nts_counter_if;

  logic                                          snapshot;  // Upper word read this cycle
  nts_stats_pkg::nts_count_u                     count;     // Live count
  logic [nts_stats_pkg::COUNT_W/2-1:0]           lsb_held;  // Lower half at last snapshot

  // Counter side
  modport counter (
    input  snapshot,
    output count,
    output lsb_held
  );

  // Readout side
  modport reader (
    output snapshot,
    input  count,
    input  lsb_held
  );

endinterface

`default_nettype wire

// File: verilog/nts_event_counter.sv
/* 64-bit event counter with a held copy of its lower half */
`timescale 1ns/1ps
`default_nettype none

module nts_event_counter (
  input  wire             i_clk,
  input  wire             i_areset,
  input  wire             i_inc,     // Single-cycle event pulse
  nts_counter_if.counter  o_cnt
);

  nts_stats_pkg::nts_count_u                count_reg;
  logic [nts_stats_pkg::COUNT_W/2-1:0]      lsb_reg;

  // --------------------
  // Count and lower-half capture
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg.word <= '0;
      lsb_reg        <= '0;
    end
    else
    begin
      if (i_inc)
      begin
        count_reg.word <= count_reg.word + 1'b1;  // Carry crosses the halves
      end

      // Value seen by the upper-word read, before this edge's increment
      if (o_cnt.snapshot)
      begin
        lsb_reg <= count_reg.half.lower;
      end
    end
  end

  assign o_cnt.count    = count_reg;
  assign o_cnt.lsb_held = lsb_reg;

endmodule

`default_nettype wire

// File: verilog/nts_debug_regs.sv
/* Debug bank with six event counters, a free-running tick counter
   and the read multiplexer for the bank */
`timescale 1ns/1ps
`default_nettype none

module nts_debug_regs (
  input  wire                                       i_clk,
  input  wire                                       i_areset,
  input  wire [nts_stats_pkg::NUM_COUNTERS-1:0]     i_events,
  nts_api_if.bank                                   i_bus
);

  localparam int N  = nts_stats_pkg::NUM_COUNTERS;
  localparam int DW = nts_api_pkg::API_DATA_W;

  logic                  bus_read;
  logic [N-1:0]          hit_upper;     // Upper-word offset addressed
  logic [N-1:0]          hit_lower;     // Lower-word offset addressed
  logic [N-1:0][DW-1:0]  upper_word;
  logic [N-1:0][DW-1:0]  held_word;
  logic [DW-1:0]         systick_reg;
  logic [DW-1:0]         read_data;

  assign bus_read = i_bus.cs && !i_bus.we;  // Writes are ignored

  // --------------------
  // Counter array
  nts_counter_if cnt_if [N] ();

  for (genvar g = 0; g < N; g++)
  begin : gen_counter
    localparam logic [nts_api_pkg::OFFSET_W-1:0] UPPER_OFFSET =
      nts_stats_pkg::COUNTER_BASE[g];
    localparam logic [nts_api_pkg::OFFSET_W-1:0] LOWER_OFFSET = UPPER_OFFSET + 8'd1;

    assign hit_upper[g] = bus_read && (i_bus.address == UPPER_OFFSET);
    assign hit_lower[g] = bus_read && (i_bus.address == LOWER_OFFSET);

    assign cnt_if[g].snapshot = hit_upper[g];  // Freeze lower half for the next read
    assign upper_word[g]      = cnt_if[g].count.half.upper;
    assign held_word[g]       = cnt_if[g].lsb_held;

    nts_event_counter counter_inst (
      .i_clk    (i_clk),
      .i_areset (i_areset),
      .i_inc    (i_events[g]),
      .o_cnt    (cnt_if[g])
    );
  end

  // --------------------
  // Tick counter
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick_reg <= nts_api_pkg::SYSTICK_RESET;
    end
    else
    begin
      systick_reg <= systick_reg + 1'b1;  // Wraps silently
    end
  end

  // --------------------
  // Read multiplexer
  always_comb
  begin
    read_data = '0;
    if (bus_read)
    begin
      case (i_bus.address)
        nts_api_pkg::ADDR_DEBUG_NAME:    read_data = nts_api_pkg::DEBUG_NAME;
        nts_api_pkg::ADDR_DEBUG_SYSTICK: read_data = systick_reg;
        default:                         read_data = '0;
      endcase

      // Counter offsets never overlap the name and tick words
      for (int i = 0; i < N; i++)
      begin
        if (hit_upper[i])
        begin
          read_data = upper_word[i];
        end
        if (hit_lower[i])
        begin
          read_data = held_word[i];
        end
      end
    end
  end

  assign i_bus.read_data = read_data;

endmodule

`default_nettype wire

// File: verilog/nts_api.sv
/* Register bus decoder with the engine identity bank and the
   bank read data select */
`timescale 1ns/1ps
`default_nettype none

module nts_api (
  input  wire                                 i_api_cs,
  input  wire                                 i_api_we,
  input  wire [nts_api_pkg::API_ADDR_W-1:0]   i_api_address,
  output wire [nts_api_pkg::API_DATA_W-1:0]   o_api_read_data,
  nts_api_if.decoder                          o_debug
);

  logic [nts_api_pkg::BANK_W-1:0]      bank;
  logic [nts_api_pkg::OFFSET_W-1:0]    offset;
  logic                                engine_read;
  logic [nts_api_pkg::API_DATA_W-1:0]  engine_data;
  logic [nts_api_pkg::API_DATA_W-1:0]  read_data;

  // --------------------
  // Address split
  assign bank   = i_api_address[nts_api_pkg::API_ADDR_W-1 -: nts_api_pkg::BANK_W];
  assign offset = i_api_address[nts_api_pkg::OFFSET_W-1:0];

  assign o_debug.cs      = i_api_cs && (bank == nts_api_pkg::BANK_DEBUG);
  assign o_debug.we      = i_api_we;
  assign o_debug.address = offset;

  // --------------------
  // Engine identity bank, read only
  assign engine_read = i_api_cs && !i_api_we && (bank == nts_api_pkg::BANK_ENGINE);

  always_comb
  begin
    engine_data = '0;
    if (engine_read)
    begin
      case (offset)
        nts_api_pkg::ADDR_NAME0:   engine_data = nts_api_pkg::CORE_NAME0;
        nts_api_pkg::ADDR_NAME1:   engine_data = nts_api_pkg::CORE_NAME1;
        nts_api_pkg::ADDR_VERSION: engine_data = nts_api_pkg::CORE_VERSION;
        nts_api_pkg::ADDR_CTRL:    engine_data = nts_api_pkg::CTRL_VALUE;  // Always 1
        default:                   engine_data = '0;
      endcase
    end
  end

  // --------------------
  // Bank select
  always_comb
  begin
    case (bank)
      nts_api_pkg::BANK_ENGINE: read_data = engine_data;
      nts_api_pkg::BANK_DEBUG:  read_data = o_debug.read_data;  // Already gated by cs
      default:                  read_data = '0;                 // Unmapped bank
    endcase
  end

  assign o_api_read_data = read_data;

endmodule

`default_nettype wire

// File: verilog/nts_engine.sv
/* Top level of the statistics and register access engine */
`timescale 1ns/1ps
`default_nettype none

module nts_engine (
  input  wire                                    i_clk,
  input  wire                                    i_areset,    // Async, active high

  // Register bus
  input  wire                                    i_api_cs,
  input  wire                                    i_api_we,
  input  wire [nts_api_pkg::API_ADDR_W-1:0]      i_api_address,
  output wire [nts_api_pkg::API_DATA_W-1:0]      o_api_read_data,

  // Event pulses in counter index order
  input  wire [nts_stats_pkg::NUM_COUNTERS-1:0]  i_events
);

  // --------------------
  // Decoder to debug bank
  nts_api_if api_bus ();

  nts_api api_inst (
    .i_api_cs        (i_api_cs),
    .i_api_we        (i_api_we),
    .i_api_address   (i_api_address),
    .o_api_read_data (o_api_read_data),
    .o_debug         (api_bus)
  );

  // --------------------
  // Counters and tick
  nts_debug_regs debug_regs_inst (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_events (i_events),
    .i_bus    (api_bus)
  );

endmodule

`default_nettype wire

// File: dv/nts_engine_asserts.sv
/* Concurrent checks on the debug bank, attached to nts_debug_regs by bind */
`timescale 1ns/1ps
`default_nettype none

module nts_engine_asserts (
  input wire                                              i_clk,
  input wire                                              i_areset,
  input wire [nts_stats_pkg::NUM_COUNTERS-1:0]            i_snapshot,
  input wire [nts_stats_pkg::NUM_COUNTERS-1:0][31:0]      i_held,
  input wire [31:0]                                       i_tick,
  input wire                                              i_cs,
  input wire [31:0]                                       i_read_data
);

  // Held lower word moves only after an upper-word read
  for (genvar g = 0; g < nts_stats_pkg::NUM_COUNTERS; g++)
  begin : gen_held
    a_held_after_snapshot : assert property (@(posedge i_clk) disable iff (i_areset)
      !$stable(i_held[g]) |-> $past(i_snapshot[g]))
      else $error("held word %0d changed without an upper-word read", g);
  end

  a_tick_step : assert property (@(posedge i_clk) disable iff (i_areset)
    !$past(i_areset) |-> (i_tick == $past(i_tick) + 32'd1))
    else $error("tick counter did not advance by one");

  a_idle_zero : assert property (@(posedge i_clk) disable iff (i_areset)
    !i_cs |-> (i_read_data == '0))  // Bank drives zero when not selected
    else $error("debug bank read data not zero while cs is low");

endmodule

bind nts_debug_regs nts_engine_asserts asserts_inst (
  .i_clk       (i_clk),
  .i_areset    (i_areset),
  .i_snapshot  (hit_upper),
  .i_held      (held_word),
  .i_tick      (systick_reg),
  .i_cs        (i_bus.cs),
  .i_read_data (i_bus.read_data)
);

`default_nettype wire

// File: dv/nts_engine_tb.sv
/* Testbench for the NTS engine register map with a stimulus table,
   a reference model of the counters and tick, and a cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module nts_engine_tb;

  localparam int RESET_CYCLES = 5;
  localparam int K_FIXED      = 0;
  localparam int K_COUNTER    = 1;
  localparam int K_TICK       = 2;

  logic        clk;
  logic        areset;
  logic        api_cs;
  logic        api_we;
  logic [11:0] api_address;
  logic [31:0] api_read_data;
  logic [5:0]  events;

  // --------------------
  // Stimulus table held as parallel queues
  string       t_name[$];
  logic [5:0]  t_mask[$];    // Events allowed in the burst
  int          t_len[$];     // Burst cycles before the access
  logic [11:0] t_addr[$];
  logic        t_we[$];
  int          t_kind[$];
  logic [31:0] t_expect[$];  // Used by K_FIXED only

  // Reference model
  logic [63:0] model_count [6];
  logic [31:0] model_held [6];
  logic [7:0]  base_offset [6] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};
  logic [31:0] lcg_state = 32'h6536ae35;
  int          edges = 0;    // Rising edges since reset release
  int          cycles = 0;
  int          limit = 0;
  int          errors = 0;

  nts_engine nts_engine_inst (
    .i_clk           (clk),
    .i_areset        (areset),
    .i_api_cs        (api_cs),
    .i_api_we        (api_we),
    .i_api_address   (api_address),
    .o_api_read_data (api_read_data),
    .i_events        (events)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (!areset)
    begin
      edges <= edges + 1;
    end
    if (cycles >= limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task add_test(input string name, input logic [5:0] mask, input int len,
                input logic [11:0] addr, input logic we, input int kind,
                input logic [31:0] exp);
    t_name.push_back(name);
    t_mask.push_back(mask);
    t_len.push_back(len);
    t_addr.push_back(addr);
    t_we.push_back(we);
    t_kind.push_back(kind);
    t_expect.push_back(exp);
  endtask

  // --------------------
  // Event burst followed by one bus access
  task run_test(input int t);
    logic [31:0] rnd;
    logic [5:0]  pulses;
    logic [31:0] expected;
    logic [31:0] actual;
    int          idx;
    for (int k = 0; k < t_len[t]; k++)
    begin
      @(posedge clk);
      rnd = lcg_next();
      pulses = t_mask[t] & rnd[29:24];
      api_cs <= 1'b0;
      events <= pulses;
      for (int i = 0; i < 6; i++)
      begin
        model_count[i] = model_count[i] + pulses[i];
      end
    end
    @(posedge clk);
    events      <= '0;
    api_cs      <= 1'b1;
    api_we      <= t_we[t];
    api_address <= t_addr[t];
    @(negedge clk);
    actual   = api_read_data;
    expected = t_expect[t];
    idx      = -1;
    for (int i = 0; i < 6; i++)
    begin
      if ((t_addr[t][7:0] & 8'hfe) == base_offset[i])
      begin
        idx = i;
      end
    end
    if (t_kind[t] == K_TICK)
    begin
      expected = 32'd1 + edges;  // Tick reads 1 right after reset
    end
    if (t_kind[t] == K_COUNTER && idx >= 0)
    begin
      if (t_addr[t][0] == 1'b0)
      begin
        expected = model_count[idx][63:32];
        model_held[idx] = model_count[idx][31:0];  // Captured at end of this read
      end
      else
      begin
        expected = model_held[idx];
      end
    end
    if (actual !== expected)
    begin
      $display("mismatch %0s: expected %h, actual %h", t_name[t], expected, actual);
      errors++;
    end
    else
    begin
      $display("ok %0s: %h", t_name[t], actual);
    end
  endtask

  initial
  begin
    clk         = 1'b0;
    areset      = 1'b1;
    api_cs      = 1'b0;
    api_we      = 1'b0;
    api_address = '0;
    events      = '0;
    for (int i = 0; i < 6; i++)
    begin
      model_count[i] = '0;
      model_held[i]  = '0;
    end

    // --------------------
    // Identity words
    add_test("engine_name0", 6'h00, 0, 12'h000, 1'b0, K_FIXED, 32'h4e54_535f);  // "NTS_"
    add_test("engine_name1", 6'h00, 0, 12'h001, 1'b0, K_FIXED, 32'h454e_474e);  // "ENGN"
    add_test("engine_version", 6'h00, 0, 12'h002, 1'b0, K_FIXED, 32'h302e_3033);
    add_test("engine_ctrl", 6'h00, 0, 12'h008, 1'b0, K_FIXED, 32'h0000_0001);
    add_test("debug_name", 6'h00, 0, 12'h108, 1'b0, K_FIXED, 32'h4442_5547);   // "DBUG"
    for (int i = 0; i < 6; i++)
    begin
      add_test($sformatf("reset_upper%0d", i), 6'h00, 0, {4'h1, base_offset[i]},
               1'b0, K_COUNTER, 0);
      add_test($sformatf("reset_lower%0d", i), 6'h00, 0, {4'h1, base_offset[i] + 8'd1},
               1'b0, K_COUNTER, 0);
    end
    for (int i = 0; i < 6; i++)
    begin
      add_test($sformatf("burst_upper%0d", i), 6'h3f, 12, {4'h1, base_offset[i]},
               1'b0, K_COUNTER, 0);
      add_test($sformatf("burst_lower%0d", i), 6'h00, 0, {4'h1, base_offset[i] + 8'd1},
               1'b0, K_COUNTER, 0);
    end
    // Lower word must come from the upper-word read and not the live count
    add_test("held_upper0", 6'h01, 4, 12'h100, 1'b0, K_COUNTER, 0);
    add_test("held_lower0", 6'h01, 10, 12'h101, 1'b0, K_COUNTER, 0);
    add_test("tick_first", 6'h00, 0, 12'h109, 1'b0, K_TICK, 0);
    add_test("tick_second", 6'h00, 7, 12'h109, 1'b0, K_TICK, 0);
    add_test("unmapped_bank2", 6'h00, 0, 12'h200, 1'b0, K_FIXED, 0);
    add_test("unmapped_bank15", 6'h00, 0, 12'hf08, 1'b0, K_FIXED, 0);
    add_test("engine_offset", 6'h00, 0, 12'h010, 1'b0, K_FIXED, 0);
    add_test("debug_offset", 6'h00, 0, 12'h1ff, 1'b0, K_FIXED, 0);
    add_test("write_engine", 6'h00, 0, 12'h000, 1'b1, K_FIXED, 0);
    add_test("write_upper0", 6'h01, 6, 12'h100, 1'b1, K_FIXED, 0);
    add_test("write_keeps_held0", 6'h00, 0, 12'h101, 1'b0, K_COUNTER, 0);
    add_test("write_upper4", 6'h3f, 5, 12'h120, 1'b1, K_FIXED, 0);
    add_test("after_write_upper4", 6'h00, 0, 12'h120, 1'b0, K_COUNTER, 0);
    add_test("after_write_lower4", 6'h00, 0, 12'h121, 1'b0, K_COUNTER, 0);
    limit = 20 * t_name.size() + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    areset <= 1'b0;
    for (int t = 0; t < t_name.size(); t++)
    begin
      run_test(t);
    end
    @(posedge clk);
    api_cs <= 1'b0;

    $display("%0d tests run, %0d errors", t_name.size(), errors);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/nts_api_pkg.sv
verilog/nts_stats_pkg.sv
verilog/nts_api_if.sv
verilog/nts_counter_if.sv
verilog/nts_event_counter.sv
verilog/nts_debug_regs.sv
verilog/nts_api.sv
verilog/nts_engine.sv
dv/nts_engine_asserts.sv
dv/nts_engine_tb.sv
